// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_mips_core
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG   := Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/decode_stage.sv ====
/*
 * IF/ID register, instruction decode and register file with write-through
 */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input  logic               clock,
	input  logic               arst_n,
	input  mips_pkg::word_t    instr_in,
	input  mips_pkg::word_t    pc_plus4,
	input  logic               hold_fetch,
	input  logic               flush_id,
	input  mips_pkg::wb_t      wb,
	output mips_pkg::id_ex_t   id_ex,
	output logic               syscall_id,
	output mips_pkg::reg_idx_t rs_id,
	output mips_pkg::reg_idx_t rt_id
);

	mips_pkg::instr_u ir;
	mips_pkg::word_t  pc_plus4_q;
	mips_pkg::word_t  regs [mips_pkg::reg_count];
	logic             uses_rs;
	logic             uses_rt;

	// $0 reads zero, a write in this cycle is seen at once
	function automatic mips_pkg::word_t read_reg(input mips_pkg::reg_idx_t idx);
		if (idx == '0)
			return '0;
		if (wb.wr_en && wb.dest == idx)
			return wb.data;
		return regs[idx];
	endfunction

	// --------------------------------------------------
	// IF/ID register
	// --------------------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ir         <= '0;
			pc_plus4_q <= '0;
		end else if (flush_id) begin
			// All-zero word falls to the no-op decode
			ir <= '0;
		end else if (!hold_fetch) begin
			ir         <= instr_in;
			pc_plus4_q <= pc_plus4;
		end
	end

	always_ff @(posedge clock) begin
		if (wb.wr_en)
			regs[wb.dest] <= wb.data;
	end

	// --------------------------------------------------
	// Decode
	// --------------------------------------------------
	always_comb begin
		id_ex          = '0;
		id_ex.pc_plus4 = pc_plus4_q;
		id_ex.rs       = ir.r_fmt.rs;
		id_ex.rt       = ir.r_fmt.rt;
		id_ex.imm      = {{16{ir.i_fmt.imm[15]}}, ir.i_fmt.imm};
		id_ex.alu_op   = mips_pkg::alu_add;
		id_ex.j_target = {pc_plus4_q[31:28], ir.j_fmt.target, 2'b00};
		syscall_id     = 1'b0;
		uses_rs        = 1'b1;
		uses_rt        = 1'b0;
		case (ir.r_fmt.op)
			mips_pkg::op_special: begin
				uses_rt     = 1'b1;
				id_ex.dest  = ir.r_fmt.rd;
				id_ex.wr_en = 1'b1;
				case (ir.r_fmt.funct)
					mips_pkg::fn_addu: id_ex.alu_op = mips_pkg::alu_add;
					mips_pkg::fn_subu: id_ex.alu_op = mips_pkg::alu_sub;
					mips_pkg::fn_and:  id_ex.alu_op = mips_pkg::alu_and;
					mips_pkg::fn_or:   id_ex.alu_op = mips_pkg::alu_or;
					mips_pkg::fn_slt:  id_ex.alu_op = mips_pkg::alu_slt;
					default: begin
						// SYSCALL and unknown functions write nothing
						syscall_id  = (ir.r_fmt.funct == mips_pkg::fn_syscall);
						id_ex.wr_en = 1'b0;
						uses_rs     = 1'b0;
						uses_rt     = 1'b0;
					end
				endcase
			end
			mips_pkg::op_addiu, mips_pkg::op_ori, mips_pkg::op_lui, mips_pkg::op_lw: begin
				id_ex.use_imm = 1'b1;
				id_ex.dest    = ir.i_fmt.rt;
				id_ex.wr_en   = 1'b1;
				id_ex.mem_rd  = (ir.i_fmt.op == mips_pkg::op_lw);
				// ORI and LUI take the zero-extended field
				if (ir.i_fmt.op == mips_pkg::op_ori || ir.i_fmt.op == mips_pkg::op_lui)
					id_ex.imm = {16'h0000, ir.i_fmt.imm};
				if (ir.i_fmt.op == mips_pkg::op_ori)
					id_ex.alu_op = mips_pkg::alu_or;
				if (ir.i_fmt.op == mips_pkg::op_lui) begin
					id_ex.alu_op = mips_pkg::alu_lui;
					uses_rs      = 1'b0;
				end
			end
			mips_pkg::op_sw: begin
				uses_rt       = 1'b1;
				id_ex.use_imm = 1'b1;
				id_ex.mem_wr  = 1'b1;
			end
			mips_pkg::op_beq, mips_pkg::op_bne: begin
				uses_rt      = 1'b1;
				id_ex.is_beq = (ir.i_fmt.op == mips_pkg::op_beq);
				id_ex.is_bne = (ir.i_fmt.op == mips_pkg::op_bne);
			end
			mips_pkg::op_j: begin
				uses_rs    = 1'b0;
				id_ex.is_j = 1'b1;
			end
			default: uses_rs = 1'b0;
		endcase
		id_ex.a = read_reg(ir.r_fmt.rs);
		id_ex.b = read_reg(ir.r_fmt.rt);
		// Only real sources go to the load-use check
		rs_id = uses_rs ? ir.r_fmt.rs : '0;
		rt_id = uses_rt ? ir.r_fmt.rt : '0;
	end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
/*
 * ID/EXE register, operand forwarding, ALU and branch resolution
 */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input  logic               clock,
	input  logic               arst_n,
	input  mips_pkg::id_ex_t   id_ex,
	input  logic               bubble_ex,
	input  mips_pkg::wb_t      wb,
	input  mips_pkg::ex_mem_t  ex_mem_fwd,
	output mips_pkg::ex_mem_t  ex_mem,
	output logic               redirect,
	output mips_pkg::word_t    redirect_pc,
	output mips_pkg::reg_idx_t load_dest,
	output logic               load_valid
);

	mips_pkg::id_ex_t id_ex_q;
	mips_pkg::word_t  op_a;
	mips_pkg::word_t  op_b;
	mips_pkg::word_t  alu_b;
	mips_pkg::word_t  alu_res;
	logic             taken;

	// Youngest producer first, $0 never forwarded
	function automatic mips_pkg::word_t fwd(input mips_pkg::reg_idx_t idx,
		input mips_pkg::word_t reg_val);
		if (idx != '0 && ex_mem_fwd.wr_en && ex_mem_fwd.dest == idx)
			return ex_mem_fwd.alu_res;
		if (idx != '0 && wb.wr_en && wb.dest == idx)
			return wb.data;
		return reg_val;
	endfunction

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			id_ex_q <= '0;
		else
			id_ex_q <= bubble_ex ? '0 : id_ex;
	end

	// --------------------------------------------------
	// Operands and ALU
	// --------------------------------------------------
	always_comb begin
		op_a  = fwd(id_ex_q.rs, id_ex_q.a);
		op_b  = fwd(id_ex_q.rt, id_ex_q.b);
		alu_b = id_ex_q.use_imm ? id_ex_q.imm : op_b;
		case (id_ex_q.alu_op)
			mips_pkg::alu_sub: alu_res = op_a - alu_b;
			mips_pkg::alu_and: alu_res = op_a & alu_b;
			mips_pkg::alu_or:  alu_res = op_a | alu_b;
			mips_pkg::alu_slt: alu_res = {31'b0, $signed(op_a) < $signed(alu_b)};
			mips_pkg::alu_lui: alu_res = {alu_b[15:0], 16'h0000};
			// Also the LW and SW address add
			default:           alu_res = op_a + alu_b;
		endcase
		ex_mem.alu_res    = alu_res;
		ex_mem.store_data = op_b;
		ex_mem.dest       = id_ex_q.dest;
		ex_mem.wr_en      = id_ex_q.wr_en;
		ex_mem.mem_rd     = id_ex_q.mem_rd;
		ex_mem.mem_wr     = id_ex_q.mem_wr;
	end

	// Branches compare forwarded values
	assign taken = (id_ex_q.is_beq && op_a == op_b) || (id_ex_q.is_bne && op_a != op_b);
	assign redirect = taken || id_ex_q.is_j;
	assign redirect_pc = id_ex_q.is_j ? id_ex_q.j_target
		: id_ex_q.pc_plus4 + {id_ex_q.imm[29:0], 2'b00};

	// Load in EXE, for the load-use check in ID
	assign load_dest  = id_ex_q.dest;
	assign load_valid = id_ex_q.mem_rd;

endmodule

`default_nettype wire

// ==== hw/fetch_pc.sv ====
/*
 * Program counter with hold and redirect load
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_pc (
	input  logic            clock,
	input  logic            arst_n,
	input  logic            hold_fetch,
	input  logic            redirect,
	input  mips_pkg::word_t redirect_pc,
	output mips_pkg::word_t pc,
	output mips_pkg::word_t pc_plus4
);

	// Sequential next address, also carried down the pipe
	assign pc_plus4 = pc + mips_pkg::pc_step;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc <= mips_pkg::reset_pc;
		end else if (redirect) begin
			// Taken branch or jump beats any stall
			pc <= redirect_pc;
		end else if (!hold_fetch) begin
			pc <= pc_plus4;
		end
	end

endmodule

`default_nettype wire

// ==== hw/hazard_ctrl.sv ====
/*
 * Load-use stall, redirect flush and SYSCALL drain FSM
 */
`timescale 1ns/1ns
`default_nettype none

module hazard_ctrl (
	input  logic               clock,
	input  logic               arst_n,
	input  logic               syscall_id,
	input  mips_pkg::reg_idx_t rs_id,
	input  mips_pkg::reg_idx_t rt_id,
	input  mips_pkg::reg_idx_t load_dest,
	input  logic               load_valid,
	input  logic               redirect,
	output logic               hold_fetch,
	output logic               flush_id,
	output logic               bubble_ex,
	output logic               sys
);

	typedef enum logic [1:0] {
		st_run,
		st_drain,
		st_notify
	} state_t;

	typedef logic [$clog2(mips_pkg::drain_cycles + 1)-1:0] cnt_t;

	state_t state_q;
	state_t state_d;
	cnt_t   cnt_q;
	logic   load_use;

	// Load in EXE feeding a source of the instruction in ID
	assign load_use = load_valid && load_dest != '0 &&
		(load_dest == rs_id || load_dest == rt_id);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= st_run;
			cnt_q   <= '0;
		end else begin
			state_q <= state_d;
			// Reloaded on every run cycle and counted down in drain
			if (state_q == st_run)
				cnt_q <= cnt_t'(mips_pkg::drain_cycles);
			else if (state_q == st_drain)
				cnt_q <= cnt_q - cnt_t'(1);
		end
	end

	// --------------------------------------------------
	// Next state and controls
	// --------------------------------------------------
	always_comb begin
		state_d    = state_q;
		hold_fetch = 1'b0;
		flush_id   = 1'b0;
		bubble_ex  = 1'b0;
		sys        = 1'b0;
		case (state_q)
			st_run: begin
				if (redirect) begin
					// Kill both younger slots and drop any SYSCALL in ID
					flush_id  = 1'b1;
					bubble_ex = 1'b1;
				end else if (syscall_id) begin
					hold_fetch = 1'b1;
					bubble_ex  = 1'b1;
					state_d    = st_drain;
				end else if (load_use) begin
					hold_fetch = 1'b1;
					bubble_ex  = 1'b1;
				end
			end
			st_drain: begin
				hold_fetch = 1'b1;
				bubble_ex  = 1'b1;
				if (cnt_q == cnt_t'(1))
					state_d = st_notify;
			end
			st_notify: begin
				// PC still held at the word after SYSCALL
				hold_fetch = 1'b1;
				flush_id   = 1'b1;
				bubble_ex  = 1'b1;
				sys        = 1'b1;
				state_d    = st_run;
			end
			default: state_d = st_run;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/mem_wb_stage.sv ====
/*
 * EXE/MEM and MEM/WB registers, data memory drive and write-back select
 */
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage (
	input  logic              clock,
	input  logic              arst_n,
	input  mips_pkg::ex_mem_t ex_mem,
	input  mips_pkg::word_t   data_in,
	output mips_pkg::ex_mem_t ex_mem_fwd,
	output mips_pkg::word_t   data_address,
	output mips_pkg::word_t   data_out,
	output logic              mem_read,
	output logic              mem_write,
	output mips_pkg::wb_t     wb
);

	mips_pkg::ex_mem_t ex_mem_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem_q <= '0;
			wb       <= '0;
		end else begin
			ex_mem_q <= ex_mem;
			// Loaded word for LW, ALU result otherwise
			wb.data  <= ex_mem_q.mem_rd ? data_in : ex_mem_q.alu_res;
			wb.dest  <= ex_mem_q.dest;
			wb.wr_en <= ex_mem_q.wr_en;
		end
	end

	// Word accesses only, memory answers in the same cycle
	assign data_address = ex_mem_q.alu_res;
	assign data_out     = ex_mem_q.store_data;
	assign mem_read     = ex_mem_q.mem_rd;
	assign mem_write    = ex_mem_q.mem_wr;
	assign ex_mem_fwd   = ex_mem_q;

endmodule

`default_nettype wire

// ==== hw/mips_core.sv ====
/*
 * Five-stage MIPS I core: fetch, decode, execute, memory and write-back
 * stages with the hazard controller
 */
`timescale 1ns/1ns
`default_nettype none

module mips_core (
	input  logic            clock,
	input  logic            arst_n,
	input  mips_pkg::word_t instr_in,
	input  mips_pkg::word_t data_in,
	output mips_pkg::word_t instruction_address,
	output mips_pkg::word_t data_address,
	output mips_pkg::word_t data_out,
	output logic            mem_read,
	output logic            mem_write,
	output logic            sys
);

	// Fetch and redirect
	mips_pkg::word_t    pc_plus4;
	mips_pkg::word_t    redirect_pc;
	logic               redirect;

	// Stage structs
	mips_pkg::id_ex_t   id_ex;
	mips_pkg::ex_mem_t  ex_mem;
	mips_pkg::ex_mem_t  ex_mem_fwd;
	mips_pkg::wb_t      wb;

	// Hazard inputs and controls
	logic               syscall_id;
	mips_pkg::reg_idx_t rs_id;
	mips_pkg::reg_idx_t rt_id;
	mips_pkg::reg_idx_t load_dest;
	logic               load_valid;
	logic               hold_fetch;
	logic               flush_id;
	logic               bubble_ex;

	// --------------------------------------------------
	// IF
	// --------------------------------------------------
	fetch_pc u_fetch_pc (
		.clock       (clock),
		.arst_n      (arst_n),
		.hold_fetch  (hold_fetch),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pc          (instruction_address),
		.pc_plus4    (pc_plus4)
	);

	// --------------------------------------------------
	// ID and EXE
	// --------------------------------------------------
	decode_stage u_decode_stage (
		.clock      (clock),
		.arst_n     (arst_n),
		.instr_in   (instr_in),
		.pc_plus4   (pc_plus4),
		.hold_fetch (hold_fetch),
		.flush_id   (flush_id),
		.wb         (wb),
		.id_ex      (id_ex),
		.syscall_id (syscall_id),
		.rs_id      (rs_id),
		.rt_id      (rt_id)
	);

	execute_stage u_execute_stage (
		.clock       (clock),
		.arst_n      (arst_n),
		.id_ex       (id_ex),
		.bubble_ex   (bubble_ex),
		.wb          (wb),
		.ex_mem_fwd  (ex_mem_fwd),
		.ex_mem      (ex_mem),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.load_dest   (load_dest),
		.load_valid  (load_valid)
	);

	// --------------------------------------------------
	// MEM, WB and hazards
	// --------------------------------------------------
	mem_wb_stage u_mem_wb_stage (
		.clock        (clock),
		.arst_n       (arst_n),
		.ex_mem       (ex_mem),
		.data_in      (data_in),
		.ex_mem_fwd   (ex_mem_fwd),
		.data_address (data_address),
		.data_out     (data_out),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.wb           (wb)
	);

	hazard_ctrl u_hazard_ctrl (
		.clock      (clock),
		.arst_n     (arst_n),
		.syscall_id (syscall_id),
		.rs_id      (rs_id),
		.rt_id      (rt_id),
		.load_dest  (load_dest),
		.load_valid (load_valid),
		.redirect   (redirect),
		.hold_fetch (hold_fetch),
		.flush_id   (flush_id),
		.bubble_ex  (bubble_ex),
		.sys        (sys)
	);

endmodule

`default_nettype wire

// ==== hw/mips_pkg.sv ====
/*
 * Shared widths, opcode and function codes, the instruction word union
 * and the structs carried between pipeline stages
 */
`default_nettype none

package mips_pkg;

	// --------------------------------------------------
	// Widths and counts
	// --------------------------------------------------
	localparam int word_w       = 32;
	localparam int reg_addr_w   = 5;
	localparam int reg_count    = 32;
	// EXE, MEM and WB emptied before sys
	localparam int drain_cycles = 3;

	typedef logic [word_w-1:0]     word_t;
	typedef logic [reg_addr_w-1:0] reg_idx_t;

	localparam word_t pc_step  = 32'd4;
	localparam word_t reset_pc = 32'h0000_0000;

	// --------------------------------------------------
	// Opcodes and SPECIAL function codes
	// --------------------------------------------------
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_j       = 6'h02;
	localparam logic [5:0] op_beq     = 6'h04;
	localparam logic [5:0] op_bne     = 6'h05;
	localparam logic [5:0] op_addiu   = 6'h09;
	localparam logic [5:0] op_ori     = 6'h0d;
	localparam logic [5:0] op_lui     = 6'h0f;
	localparam logic [5:0] op_lw      = 6'h23;
	localparam logic [5:0] op_sw      = 6'h2b;

	localparam logic [5:0] fn_syscall = 6'h0c;
	localparam logic [5:0] fn_addu    = 6'h21;
	localparam logic [5:0] fn_subu    = 6'h23;
	localparam logic [5:0] fn_and     = 6'h24;
	localparam logic [5:0] fn_or      = 6'h25;
	localparam logic [5:0] fn_slt     = 6'h2a;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_t;

	// One fetched word, three decode views
	typedef union packed {
		struct packed {
			logic [5:0] op;
			reg_idx_t   rs;
			reg_idx_t   rt;
			reg_idx_t   rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r_fmt;
		struct packed {
			logic [5:0]  op;
			reg_idx_t    rs;
			reg_idx_t    rt;
			logic [15:0] imm;
		} i_fmt;
		struct packed {
			logic [5:0]  op;
			logic [25:0] target;
		} j_fmt;
	} instr_u;

	// --------------------------------------------------
	// Stage payloads
	// --------------------------------------------------
	typedef struct packed {
		word_t    pc_plus4;
		reg_idx_t rs;
		reg_idx_t rt;
		word_t    a;
		word_t    b;
		// Already sign or zero extended
		word_t    imm;
		alu_op_t  alu_op;
		logic     use_imm;
		reg_idx_t dest;
		logic     wr_en;
		logic     mem_rd;
		logic     mem_wr;
		logic     is_beq;
		logic     is_bne;
		logic     is_j;
		word_t    j_target;
	} id_ex_t;

	typedef struct packed {
		word_t    alu_res;
		word_t    store_data;
		reg_idx_t dest;
		logic     wr_en;
		logic     mem_rd;
		logic     mem_wr;
	} ex_mem_t;

	typedef struct packed {
		word_t    data;
		reg_idx_t dest;
		logic     wr_en;
	} wb_t;

endpackage

`default_nettype wire

// ==== sources.f ====
hw/mips_pkg.sv
hw/fetch_pc.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/hazard_ctrl.sv
hw/mips_core.sv
test/mips_core_chk.sv
test/tb_mips_core.sv

// ==== test/mips_core_chk.sv ====
/*
 * Concurrent checks on the core's memory strobes and sys pulse
 */
`timescale 1ns/1ns
`default_nettype none

module mips_core_chk (
	input logic clock,
	input logic arst_n,
	input logic mem_read,
	input logic mem_write,
	input logic sys
);

	// Bumped by every failing assertion
	int fail_count = 0;

	// One memory strobe per cycle
	rd_wr_excl: assert property (@(posedge clock) disable iff (!arst_n)
		!(mem_read && mem_write))
	else begin
		$error("mem_read and mem_write high in the same cycle");
		fail_count++;
	end

	// sys is a single-cycle pulse
	sys_single: assert property (@(posedge clock) disable iff (!arst_n)
		sys |=> !sys)
	else begin
		$error("sys high for two cycles in a row");
		fail_count++;
	end

	// Strobes quiet while reset is held
	reset_quiet: assert property (@(posedge clock)
		!arst_n |-> (!mem_read && !mem_write && !sys))
	else begin
		$error("memory strobe or sys active during reset");
		fail_count++;
	end

endmodule

bind mips_core mips_core_chk u_chk (
	.clock     (clock),
	.arst_n    (arst_n),
	.mem_read  (mem_read),
	.mem_write (mem_write),
	.sys       (sys)
);

`default_nettype wire

// ==== test/tb_mips_core.sv ====
/*
 * Testbench for the MIPS core: clock, reset, memory models, directed
 * tests for ALU, load-use, branch and SYSCALL behavior
 */
`timescale 1ns/1ns
`default_nettype none

module tb_mips_core;

	localparam int wait_limit = 300;

	logic            clock  = 1'b0;
	logic            arst_n = 1'b1;
	mips_pkg::word_t instr_in;
	mips_pkg::word_t data_in;
	mips_pkg::word_t instruction_address;
	mips_pkg::word_t data_address;
	mips_pkg::word_t data_out;
	logic            mem_read;
	logic            mem_write;
	logic            sys;

	// Memory models
	mips_pkg::word_t imem [256];
	mips_pkg::word_t dmem [256];
	logic [255:0]    written = '0;
	logic            poke_en = 1'b0;
	mips_pkg::word_t poke_addr = '0;
	mips_pkg::word_t poke_val = '0;

	// Observed stores, loads and sys pulses
	mips_pkg::word_t st_addr [$];
	mips_pkg::word_t st_data [$];
	mips_pkg::word_t ld_addr [$];
	int              sys_count = 0;
	int              stores_at_sys = 0;

	// Expected stores of the running test
	mips_pkg::word_t exp_addr [$];
	mips_pkg::word_t exp_data [$];
	mips_pkg::word_t prog_pc;
	int              store_base;
	int              ld_base;
	int              sys_base;
	integer          seed;
	int              checks = 0;
	int              errors = 0;

	mips_core u_dut (
		.clock               (clock),
		.arst_n              (arst_n),
		.instr_in            (instr_in),
		.data_in             (data_in),
		.instruction_address (instruction_address),
		.data_address        (data_address),
		.data_out            (data_out),
		.mem_read            (mem_read),
		.mem_write           (mem_write),
		.sys                 (sys)
	);

	initial begin
		forever #50 clock = ~clock;
	end

	// Unwritten data words read back a value tied to the full address
	function automatic mips_pkg::word_t fill_word(input mips_pkg::word_t addr);
		return addr ^ 32'hc3a5_0f96;
	endfunction

	// Both memories answer in the same cycle
	assign instr_in = imem[instruction_address[9:2]];
	assign data_in  = written[data_address[9:2]] ? dmem[data_address[9:2]]
		: fill_word(data_address);

	always @(posedge clock) begin
		if (poke_en) begin
			dmem[poke_addr[9:2]]    <= poke_val;
			written[poke_addr[9:2]] <= 1'b1;
		end
		if (mem_write) begin
			dmem[data_address[9:2]]    <= data_out;
			written[data_address[9:2]] <= 1'b1;
			st_addr.push_back(data_address);
			st_data.push_back(data_out);
		end
		if (mem_read)
			ld_addr.push_back(data_address);
		if (sys) begin
			sys_count     = sys_count + 1;
			stores_at_sys = st_addr.size();
		end
	end

	// --------------------------------------------------
	// Instruction encoding and ISA helpers
	// --------------------------------------------------
	function automatic mips_pkg::word_t r_type(input logic [5:0] funct,
		input mips_pkg::reg_idx_t rs, input mips_pkg::reg_idx_t rt,
		input mips_pkg::reg_idx_t rd);
		return {mips_pkg::op_special, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic mips_pkg::word_t i_type(input logic [5:0] op,
		input mips_pkg::reg_idx_t rs, input mips_pkg::reg_idx_t rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_pkg::word_t j_type(input mips_pkg::word_t target);
		return {mips_pkg::op_j, target[27:2]};
	endfunction

	function automatic mips_pkg::word_t sext16(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	task automatic emit(input mips_pkg::word_t w);
		imem[prog_pc[9:2]] = w;
		prog_pc = prog_pc + 32'd4;
	endtask

	task automatic expect_store(input mips_pkg::word_t addr, input mips_pkg::word_t val);
		exp_addr.push_back(addr);
		exp_data.push_back(val);
	endtask

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic check_word(input mips_pkg::word_t got, input mips_pkg::word_t want,
		input string what);
		checks++;
		if (got !== want) begin
			$display("FAIL %0t: %s, got %h, expected %h", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic check_bit(input logic got, input logic want, input string what);
		checks++;
		if (got !== want) begin
			$display("FAIL %0t: %s, got %b, expected %b", $time, what, got, want);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// Reset, program load and wait
	// --------------------------------------------------
	task automatic hold_reset;
		@(posedge clock);
		arst_n <= 1'b0;
		repeat (15) @(posedge clock);
	endtask

	task automatic release_reset;
		@(posedge clock);
		arst_n <= 1'b1;
	endtask

	task automatic poke_word(input mips_pkg::word_t addr, input mips_pkg::word_t val);
		@(posedge clock);
		poke_en   <= 1'b1;
		poke_addr <= addr;
		poke_val  <= val;
		@(posedge clock);
		poke_en <= 1'b0;
	endtask

	// Called with reset held and no stores in flight
	task automatic start_program;
		for (int i = 0; i < 256; i++)
			imem[i] = '0;
		prog_pc = mips_pkg::reset_pc;
		exp_addr.delete();
		exp_data.delete();
		store_base = st_addr.size();
		ld_base    = ld_addr.size();
		sys_base   = sys_count;
	endtask

	// Second arrival at the parking jump means it has looped back once
	task automatic wait_parked(input mips_pkg::word_t park_pc, input string name);
		int   cycles;
		int   entries;
		logic at_park;
		cycles  = 0;
		entries = 0;
		at_park = 1'b0;
		while (entries < 2 && cycles < wait_limit) begin
			@(negedge clock);
			if (instruction_address == park_pc && !at_park)
				entries++;
			at_park = (instruction_address == park_pc);
			cycles++;
		end
		if (entries < 2) begin
			$display("ERROR %0t: %s did not reach its parking jump in time", $time, name);
			errors++;
		end
	endtask

	task automatic compare_stores(input string name);
		int n;
		n = st_addr.size() - store_base;
		check_word(mips_pkg::word_t'(n), mips_pkg::word_t'(exp_addr.size()),
			{name, ": store count"});
		for (int i = 0; i < exp_addr.size() && i < n; i++) begin
			check_word(st_addr[store_base + i], exp_addr[i],
				$sformatf("%s: store %0d address", name, i));
			check_word(st_data[store_base + i], exp_data[i],
				$sformatf("%s: store %0d data", name, i));
		end
	endtask

	// Park on a jump to itself and run until every older store is out
	task automatic run_program(input string name);
		mips_pkg::word_t park_pc;
		park_pc = prog_pc;
		emit(j_type(park_pc));
		release_reset();
		wait_parked(park_pc, name);
		compare_stores(name);
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic reset_values;
		hold_reset();
		@(negedge clock);
		check_word(instruction_address, mips_pkg::reset_pc, "pc during reset");
		check_bit(mem_read, 1'b0, "mem_read during reset");
		check_bit(mem_write, 1'b0, "mem_write during reset");
		check_bit(sys, 1'b0, "sys during reset");
		release_reset();
		@(negedge clock);
		check_word(instruction_address, mips_pkg::reset_pc, "pc at first edge after reset");
		check_bit(mem_read, 1'b0, "mem_read after reset");
		check_bit(mem_write, 1'b0, "mem_write after reset");
		check_bit(sys, 1'b0, "sys after reset");
		@(negedge clock);
		check_word(instruction_address, mips_pkg::reset_pc + mips_pkg::pc_step,
			"pc after first fetch");
	endtask

	task automatic alu_chain;
		logic [15:0]     k1;
		logic [15:0]     k2;
		logic [15:0]     k3;
		logic [15:0]     k4;
		mips_pkg::word_t v [10];
		k1 = 16'($random(seed));
		k2 = 16'($random(seed));
		k3 = 16'($random(seed));
		k4 = 16'($random(seed));
		// Reference results
		v[0] = '0;
		v[1] = sext16(k1);
		v[2] = v[1] + sext16(k2);
		v[3] = v[2] + v[1];
		v[4] = v[3] - v[1];
		v[5] = v[4] & v[3];
		v[6] = v[5] | v[2];
		v[7] = ($signed(v[6]) < $signed(v[4])) ? 32'd1 : 32'd0;
		v[8] = {k3, 16'h0000};
		v[9] = v[8] | {16'h0000, k4};
		hold_reset();
		start_program();
		emit(i_type(mips_pkg::op_addiu, 5'd0, 5'd1, k1));
		emit(i_type(mips_pkg::op_addiu, 5'd1, 5'd2, k2));
		emit(r_type(mips_pkg::fn_addu, 5'd2, 5'd1, 5'd3));
		emit(r_type(mips_pkg::fn_subu, 5'd3, 5'd1, 5'd4));
		emit(r_type(mips_pkg::fn_and, 5'd4, 5'd3, 5'd5));
		emit(r_type(mips_pkg::fn_or, 5'd5, 5'd2, 5'd6));
		emit(r_type(mips_pkg::fn_slt, 5'd6, 5'd4, 5'd7));
		emit(i_type(mips_pkg::op_lui, 5'd0, 5'd8, k3));
		emit(i_type(mips_pkg::op_ori, 5'd8, 5'd9, k4));
		// Store $9 first straight after ORI
		for (int r = 9; r >= 1; r--) begin
			emit(i_type(mips_pkg::op_sw, 5'd0, mips_pkg::reg_idx_t'(r),
				16'(32'h40 + 4 * r)));
			expect_store(32'h40 + 4 * r, v[r]);
		end
		run_program("alu chain");
	endtask

	task automatic load_use;
		mips_pkg::word_t w0;
		mips_pkg::word_t w1;
		logic [15:0]     k;
		int              n;
		w0 = $random(seed);
		w1 = $random(seed);
		k  = 16'($random(seed));
		poke_word(32'h80, w0);
		poke_word(32'h88, w1);
		hold_reset();
		start_program();
		emit(i_type(mips_pkg::op_addiu, 5'd0, 5'd10, k));
		emit(i_type(mips_pkg::op_lw, 5'd0, 5'd11, 16'h0080));
		emit(r_type(mips_pkg::fn_addu, 5'd11, 5'd10, 5'd12));
		emit(i_type(mips_pkg::op_sw, 5'd0, 5'd12, 16'h0084));
		// Loaded value used as store data
		emit(i_type(mips_pkg::op_lw, 5'd0, 5'd13, 16'h0088));
		emit(i_type(mips_pkg::op_sw, 5'd0, 5'd13, 16'h008c));
		expect_store(32'h84, w0 + sext16(k));
		expect_store(32'h8c, w1);
		run_program("load use");
		// Each LW reads the data memory once at its own address
		n = ld_addr.size() - ld_base;
		check_word(mips_pkg::word_t'(n), 32'd2, "load use: load count");
		if (n == 2) begin
			check_word(ld_addr[ld_base], 32'h80, "load use: load 0 address");
			check_word(ld_addr[ld_base + 1], 32'h88, "load use: load 1 address");
		end
	endtask

	task automatic branch_paths;
		logic [15:0]     k;
		mips_pkg::word_t r;
		k = 16'($random(seed));
		r = sext16(k);
		hold_reset();
		start_program();
		emit(i_type(mips_pkg::op_addiu, 5'd0, 5'd1, k));
		emit(i_type(mips_pkg::op_addiu, 5'd1, 5'd2, 16'h0000));
		// Taken branch skips two stores
		emit(i_type(mips_pkg::op_beq, 5'd1, 5'd2, 16'd2));
		emit(i_type(mips_pkg::op_sw, 5'd0, 5'd1, 16'h00a0));
		emit(i_type(mips_pkg::op_sw, 5'd0, 5'd1, 16'h00a4));
		// Not taken so the next store stays
		emit(i_type(mips_pkg::op_bne, 5'd1, 5'd2, 16'd5));
		emit(i_type(mips_pkg::op_sw, 5'd0, 5'd2, 16'h00a8));
		emit(j_type(prog_pc + 32'd12));
		emit(i_type(mips_pkg::op_sw, 5'd0, 5'd1, 16'h00ac));
		emit(i_type(mips_pkg::op_sw, 5'd0, 5'd1, 16'h00b0));
		emit(i_type(mips_pkg::op_sw, 5'd0, 5'd2, 16'h00b4));
		expect_store(32'ha8, r);
		expect_store(32'hb4, r);
		run_program("branches");
	endtask

	task automatic syscall_drain;
		logic [15:0]     k;
		mips_pkg::word_t r;
		k = 16'($random(seed));
		r = sext16(k);
		hold_reset();
		start_program();
		emit(i_type(mips_pkg::op_addiu, 5'd0, 5'd1, k));
		emit(i_type(mips_pkg::op_sw, 5'd0, 5'd1, 16'h00c0));
		emit({mips_pkg::op_special, 20'd0, mips_pkg::fn_syscall});
		emit(i_type(mips_pkg::op_addiu, 5'd1, 5'd2, 16'h0001));
		emit(i_type(mips_pkg::op_sw, 5'd0, 5'd2, 16'h00c4));
		expect_store(32'hc0, r);
		expect_store(32'hc4, r + 32'd1);
		run_program("syscall");
		check_word(mips_pkg::word_t'(sys_count - sys_base), 32'd1, "syscall: sys pulses");
		// Older store already in memory when sys fired
		check_word(mips_pkg::word_t'(stores_at_sys - store_base), 32'd1,
			"syscall: stores before sys");
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		seed = 32'h9610_de8b;
		for (int i = 0; i < 256; i++)
			imem[i] = '0;
		prog_pc    = mips_pkg::reset_pc;
		store_base = 0;
		ld_base    = 0;
		sys_base   = 0;
		// Falling edge at time zero resets the core
		arst_n <= 1'b0;
		reset_values();
		alu_chain();
		load_use();
		branch_paths();
		syscall_drain();
		errors = errors + u_dut.u_chk.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
